// ==== src/nbbpu_consts.svh ====
// ----------------------------------------------------------
// Core-wide constants for the NBBPU 16-bit processor
// Include in any file that sizes words, registers or opcodes
// ----------------------------------------------------------
`ifndef NBBPU_CONSTS_SVH
`define NBBPU_CONSTS_SVH

// Datapath sizing
`define NBBPU_WORD_W   16          // Data and address width
`define NBBPU_NREGS    16          // All of them writable

// Pc value after reset
`define NBBPU_RESET_PC 16'h0000

// ----------------------------------------------------------
// Opcode encodings, top nibble of the instruction
// ----------------------------------------------------------
`define NBBPU_OP_ADD   4'h0
`define NBBPU_OP_SUB   4'h1
`define NBBPU_OP_AND   4'h2
`define NBBPU_OP_IOR   4'h3
`define NBBPU_OP_XOR   4'h4
`define NBBPU_OP_SHR   4'h5
`define NBBPU_OP_SHL   4'h6
`define NBBPU_OP_CMP   4'h7        // Unsigned less-than
`define NBBPU_OP_JMP   4'h8        // Jump and link
`define NBBPU_OP_BRE   4'h9        // Branch if rd is zero
`define NBBPU_OP_BRN   4'hA        // Branch if rd is non-zero
`define NBBPU_OP_RES   4'hB        // Halt
`define NBBPU_OP_LOD   4'hC
`define NBBPU_OP_STR   4'hD
`define NBBPU_OP_SEL   4'hE        // Set low byte
`define NBBPU_OP_SEU   4'hF        // Set high byte

`endif

// ==== src/nbbpu_pkg.sv ====
// ----------------------------------------------------------
// Shared types for the NBBPU core
// Instruction layout, opcode and ALU enums, control bundle
// ----------------------------------------------------------
`include "nbbpu_consts.svh"

package nbbpu_pkg;

    typedef logic [`NBBPU_WORD_W-1:0] word_t;
    typedef logic [3:0]               reg_addr_t;   // One of sixteen registers

    // Opcodes in decoder order
    typedef enum logic [3:0] {
        OP_ADD = `NBBPU_OP_ADD,
        OP_SUB = `NBBPU_OP_SUB,
        OP_AND = `NBBPU_OP_AND,
        OP_IOR = `NBBPU_OP_IOR,
        OP_XOR = `NBBPU_OP_XOR,
        OP_SHR = `NBBPU_OP_SHR,
        OP_SHL = `NBBPU_OP_SHL,
        OP_CMP = `NBBPU_OP_CMP,
        OP_JMP = `NBBPU_OP_JMP,
        OP_BRE = `NBBPU_OP_BRE,
        OP_BRN = `NBBPU_OP_BRN,
        OP_RES = `NBBPU_OP_RES,
        OP_LOD = `NBBPU_OP_LOD,
        OP_STR = `NBBPU_OP_STR,
        OP_SEL = `NBBPU_OP_SEL,
        OP_SEU = `NBBPU_OP_SEU
    } opcode_e;

    // Instruction word, msb first
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;      // Destination, or branch test register
        reg_addr_t ra;      // Source a, high nibble of immediate
        reg_addr_t rb;      // Source b, low nibble of immediate
    } instr_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_IOR, ALU_XOR,
        ALU_SHR, ALU_SHL, ALU_CMP_LT,
        ALU_SET_LOW, ALU_SET_HIGH, ALU_PASS_LINK
    } alu_op_e;

    // Decoded control bundle
    typedef struct packed {
        logic    reg_write;         // Writes rd
        logic    reg_set;           // Byte-set instruction
        logic    data_write;        // Store
        logic    mem_to_reg;        // Load
        logic    pc_select;         // Jump or branch possible
        logic    branch_on_zero;    // BRE rather than BRN or JMP
        logic    jump;              // Unconditional
        logic    halt;              // RES
        alu_op_e alu_op;
    } ctrl_t;

endpackage

// ==== src/controller.sv ====
// ----------------------------------------------------------
// Opcode decoder of the NBBPU
// Purely combinational, turns an opcode into the control bundle
// ----------------------------------------------------------
module controller import nbbpu_pkg::*; (
    input  opcode_e opcode,
    output ctrl_t   ctrl
);

    always_comb begin
        ctrl        = '0;           // Nothing written by default
        ctrl.alu_op = ALU_ADD;
        case (opcode)
            // Register-register ALU group
            OP_ADD: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_ADD;    end
            OP_SUB: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_SUB;    end
            OP_AND: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_AND;    end
            OP_IOR: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_IOR;    end
            OP_XOR: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_XOR;    end
            OP_SHR: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_SHR;    end
            OP_SHL: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_SHL;    end
            OP_CMP: begin ctrl.reg_write = 1'b1; ctrl.alu_op = ALU_CMP_LT; end

            // Control flow
            OP_JMP: begin
                ctrl.reg_write = 1'b1;          // Link into rd
                ctrl.pc_select = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.alu_op    = ALU_PASS_LINK;
            end
            OP_BRE: begin
                ctrl.pc_select      = 1'b1;
                ctrl.branch_on_zero = 1'b1;
            end
            OP_BRN: begin
                ctrl.pc_select = 1'b1;          // Taken on non-zero
            end
            OP_RES: begin
                ctrl.halt = 1'b1;
            end

            // Memory
            OP_LOD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_STR: begin
                ctrl.data_write = 1'b1;
            end

            // Byte set from the 8-bit immediate
            OP_SEL: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_set   = 1'b1;
                ctrl.alu_op    = ALU_SET_LOW;
            end
            OP_SEU: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_set   = 1'b1;
                ctrl.alu_op    = ALU_SET_HIGH;
            end
            default: begin
                ctrl = '0;                      // Every write inactive
            end
        endcase
    end

endmodule

// ==== src/alu.sv ====
// ----------------------------------------------------------
// Combinational ALU of the NBBPU
// Produces every register result from arithmetic, logic,
// shifts, the unsigned compare, the byte set and the jump link
// ----------------------------------------------------------
`include "nbbpu_consts.svh"

module alu import nbbpu_pkg::*; (
    input  alu_op_e    alu_op,
    input  word_t      a,          // Value of ra
    input  word_t      b,          // Value of rb
    input  word_t      d,          // Current value of rd
    input  word_t      pc,
    input  logic [7:0] imm,        // {ra, rb} fields
    output word_t      result
);

    logic [3:0] shamt;             // Shift amount
    logic       lt;                // Unsigned a < b

    assign shamt = b[3:0];
    assign lt    = (a < b);

    always_comb begin
        case (alu_op)
            ALU_ADD:       result = a + b;
            ALU_SUB:       result = a - b;
            ALU_AND:       result = a & b;
            ALU_IOR:       result = a | b;
            ALU_XOR:       result = a ^ b;
            ALU_SHR:       result = a >> shamt;         // Logical
            ALU_SHL:       result = a << shamt;
            ALU_CMP_LT:    result = {{(`NBBPU_WORD_W-1){1'b0}}, lt};

            // Keep the other byte of rd
            ALU_SET_LOW:   result = {d[15:8], imm};
            ALU_SET_HIGH:  result = {imm, d[7:0]};

            // Return address for JMP
            ALU_PASS_LINK: result = pc + 16'd1;
            default:       result = '0;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
// ----------------------------------------------------------
// Register file, sixteen 16-bit registers, all writable
// Three asynchronous read ports, one write port at the clock
// edge. The rd port feeds the branch test and the byte set
// ----------------------------------------------------------
`include "nbbpu_consts.svh"

module reg_file import nbbpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t ra,
    input  reg_addr_t rb,
    input  reg_addr_t rd,
    output word_t     ra_val,
    output word_t     rb_val,
    output word_t     rd_val
);

    word_t regs [`NBBPU_NREGS];

    // Write port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NBBPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;               // Visible next cycle
        end
    end

    // Read ports, zero latency
    assign ra_val = regs[ra];
    assign rb_val = regs[rb];
    assign rd_val = regs[rd];   // Branch test and byte set

endmodule

// ==== src/pc_unit.sv ====
// ----------------------------------------------------------
// Program counter and halt state of the NBBPU
// Picks the next pc from jump, branch test or increment,
// and freezes on RES until reset
// ----------------------------------------------------------
`include "nbbpu_consts.svh"

module pc_unit import nbbpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  ctrl_t ctrl,
    input  word_t test_val,         // Value of rd for BRE or BRN
    input  word_t target,           // Jump or branch destination
    output word_t pc,
    output logic  halted,
    output logic  commit            // Instruction retires this edge
);

    logic  is_zero;
    logic  take;
    word_t pc_next;

    // Branch decision
    assign is_zero = (test_val == '0);
    assign take    = ctrl.jump |
                     (ctrl.pc_select & (is_zero == ctrl.branch_on_zero));

    assign pc_next = take ? target : pc + 16'd1;
    assign commit  = ~halted;

    // ------------------------------------------------------
    // State update
    // ------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= `NBBPU_RESET_PC;
            halted <= 1'b0;
        end else if (commit) begin
            if (ctrl.halt) begin
                halted <= 1'b1;             // Pc stays on the RES
            end else begin
                pc <= pc_next;
            end
        end
    end

endmodule

// ==== src/nbbpu.sv ====
// ----------------------------------------------------------
// NBBPU single-cycle core, top level
// Connects decoder, register file, ALU and pc unit to the
// external instruction and data memories, both read
// combinationally. One instruction retires per clock edge
// ----------------------------------------------------------
module nbbpu import nbbpu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,

    // Instruction memory
    output word_t pc,
    input  word_t instr,

    // Data memory
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_we,
    input  word_t mem_rdata,

    output logic  halted
);

    instr_t ins;
    ctrl_t  ctrl;
    word_t  ra_val;
    word_t  rb_val;
    word_t  rd_val;
    word_t  result;
    word_t  wb_data;
    word_t  target;
    logic   commit;
    logic   rf_we;

    assign ins = instr_t'(instr);

    // ------------------------------------------------------
    // Decode and register access
    // ------------------------------------------------------
    controller u_ctrl (
        .opcode (ins.opcode),
        .ctrl   (ctrl)
    );

    assign rf_we   = ctrl.reg_write & commit;                  // No writes once halted
    assign wb_data = ctrl.mem_to_reg ? mem_rdata : result;     // Load or ALU

    reg_file u_rf (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (rf_we),
        .waddr  (ins.rd),
        .wdata  (wb_data),
        .ra     (ins.ra),
        .rb     (ins.rb),
        .rd     (ins.rd),
        .ra_val (ra_val),
        .rb_val (rb_val),
        .rd_val (rd_val)
    );

    // ------------------------------------------------------
    // Execute and next pc
    // ------------------------------------------------------
    alu u_alu (
        .alu_op (ctrl.alu_op),
        .a      (ra_val),
        .b      (rb_val),
        .d      (rd_val),
        .pc     (pc),
        .imm    ({ins.ra, ins.rb}),
        .result (result)
    );

    // JMP goes to ra, branches to rb
    assign target = ctrl.jump ? ra_val : rb_val;

    pc_unit u_pc (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .test_val (rd_val),
        .target   (target),
        .pc       (pc),
        .halted   (halted),
        .commit   (commit)
    );

    // Data memory port
    assign mem_addr  = ra_val;
    assign mem_wdata = rb_val;
    assign mem_we    = ctrl.data_write & commit;

endmodule

// ==== verification/tb_clock.sv ====
// ----------------------------------------------------------
// Clock and reset source for the NBBPU testbench
// Free-running clock, reset held low for the first cycles
// ----------------------------------------------------------
module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // Half period per phase
    end

    initial begin
        arst_n = 1'b0;                          // Asserted from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;                         // Released on a rising edge
    end

endmodule

// ==== verification/nbbpu_asserts.sv ====
// ----------------------------------------------------------
// Assertion checker bound into the NBBPU top level
// Watches the store enable around reset and the halt state
// ----------------------------------------------------------
module nbbpu_asserts (
    input logic        clk,
    input logic        arst_n,
    input logic [15:0] pc,
    input logic        mem_we,
    input logic        halted
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;     // Summed into the testbench result

    // Core held in reset never stores
    no_store_in_reset: assert property (@(posedge clk) !arst_n |-> !mem_we)
        else begin
            fail_count++;
            $error("mem_we high while arst_n is low");
        end

    // Pc frozen on the RES
    pc_frozen_when_halted: assert property (
        @(posedge clk) disable iff (!arst_n) halted |=> $stable(pc))
        else begin
            fail_count++;
            $error("pc moved while halted");
        end

    no_store_when_halted: assert property (
        @(posedge clk) disable iff (!arst_n) halted |-> !mem_we)
        else begin
            fail_count++;
            $error("mem_we high while halted");
        end

endmodule

bind nbbpu nbbpu_asserts u_asserts (
    .clk    (clk),
    .arst_n (arst_n),
    .pc     (pc),
    .mem_we (mem_we),
    .halted (halted)
);

// ==== verification/tb_nbbpu.sv ====
// ----------------------------------------------------------
// Testbench for the NBBPU core
// Loads program, data and expected results from the patterns
// file, models both memories, checks every store and the halt
// ----------------------------------------------------------
module tb_nbbpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_DEPTH   = 256;   // Indexed by the low address byte
    localparam int PAT_DEPTH   = 128;
    localparam int TIMEOUT     = 2000;  // Cycles allowed to reach RES
    localparam int TAIL_CYCLES = 4;     // Watched after the halt

    logic        clk;
    logic        arst_n;
    logic [15:0] pc;
    logic [15:0] instr;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic [15:0] mem_rdata;
    logic        mem_we;
    logic        halted;

    logic [35:0] pat  [PAT_DEPTH];      // {tag, addr, data}
    logic [15:0] imem [MEM_DEPTH];
    logic [15:0] dmem [MEM_DEPTH];
    logic [31:0] exp_stores [$];        // {addr, data}, in program order
    logic [15:0] exp_halt_pc;
    int          store_idx;
    int          checks;
    int          errors;

    tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(5)) u_clock (.clk, .arst_n);

    nbbpu dut0 (.*);

    // Both memories answer within the cycle
    assign instr     = imem[pc[7:0]];
    assign mem_rdata = dmem[mem_addr[7:0]];

    // ------------------------------------------------------
    // Helpers
    // ------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [15:0] want,
                                   input logic [15:0] got);
        $display("MISMATCH %s: expected %h actual %h", name, want, got);
        errors++;
    endtask

    task automatic load_patterns();
        logic [3:0]  tag;
        logic [15:0] addr;
        logic [15:0] data;
        exp_halt_pc = 16'hFFFF;                     // Until an H entry
        for (int i = 0; i < MEM_DEPTH; i++) begin
            imem[i]  = 16'hB000 | 16'(i);           // RES, address in its fields
            dmem[i] <= 16'(i * 257) ^ 16'h5A5A;
        end
        $readmemh("verification/nbbpu_patterns.txt", pat);
        for (int i = 0; i < PAT_DEPTH; i++) begin
            tag  = pat[i][35:32];
            addr = pat[i][31:16];
            data = pat[i][15:0];
            case (tag)
                4'h1:    imem[addr[7:0]] = data;    // Program word
                4'h2:    dmem[addr[7:0]] <= data;   // Preloaded data
                4'h3:    exp_stores.push_back({addr, data});
                4'h4:    exp_halt_pc = addr;
                default: ;                          // Unused slot
            endcase
        end
    endtask

    task automatic check_store(input logic [15:0] addr, input logic [15:0] data);
        logic [31:0] want;
        if (store_idx >= exp_stores.size()) begin
            $display("ERROR: unexpected store of %h to address %h", data, addr);
            errors++;
        end else begin
            want = exp_stores[store_idx];
            checks++;
            if (want[31:16] !== addr) begin
                report_mismatch($sformatf("store%0d_addr", store_idx), want[31:16], addr);
            end
            if (want[15:0] !== data) begin
                report_mismatch($sformatf("store%0d_data", store_idx), want[15:0], data);
            end
        end
        store_idx++;
    endtask

    // ------------------------------------------------------
    // Data memory write port and store monitor
    // ------------------------------------------------------
    always @(posedge clk) begin
        if (arst_n && mem_we) begin
            dmem[mem_addr[7:0]] <= mem_wdata;
        end
    end

    always @(negedge clk) begin
        if (arst_n && mem_we) begin
            check_store(mem_addr, mem_wdata);       // Mid-cycle, values settled
        end
    end

    initial begin
        int cycles;
        store_idx = 0;
        checks    = 0;
        errors    = 0;
        load_patterns();
        if (exp_stores.size() == 0) begin
            $display("ERROR: no expected stores found in the patterns file");
            errors++;
        end

        // Run until RES commits
        cycles = 0;
        while (halted !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("ERROR: core did not halt within %0d cycles", TIMEOUT);
            errors++;
        end else begin
            checks++;
            if (pc !== exp_halt_pc) begin
                report_mismatch("halt_pc", exp_halt_pc, pc);
            end
            for (int i = 0; i < TAIL_CYCLES; i++) begin
                @(negedge clk);
                checks++;
                if (pc !== exp_halt_pc) begin
                    report_mismatch("pc_after_halt", exp_halt_pc, pc);
                end
                if (halted !== 1'b1) begin
                    $display("ERROR: halted dropped after RES");
                    errors++;
                end
            end
        end

        checks++;
        if (store_idx != exp_stores.size()) begin
            $display("ERROR: saw %0d stores, expected %0d", store_idx, exp_stores.size());
            errors++;
        end
        if (dut0.u_asserts.fail_count != 0) begin
            $display("ERROR: %0d assertion failures", dut0.u_asserts.fail_count);
            errors += dut0.u_asserts.fail_count;
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verification/nbbpu_patterns.txt ====
// Each word is tag, 16-bit address, 16-bit data (9 hex digits)
// Tags: 1 program word, 2 preloaded data, 3 expected store in order, 4 halt pc
// Byte set: r1 = 1234, r3 = F00F, r4 = 0005, each stored at its own value
10000E134 10001F112 10002D011 10003E30F 10004F3F0 10005D033
10006E405
// ALU results in r5 stored at their own value; SHL takes 4 from r1 low bits
100070513 10008D055 100091513 1000AD055 1000B2513 1000CD055
1000D3513 1000ED055 1000F4513 10010D055 100115514 10012D055
100136531 10014D055 100157513 10016D055 100177531 10018D055
// Loads from 0080 and 0081, written back at 0090 and 0091
10019E780 1001AC870 1001BE990 1001CD098
1001DE781 1001EC870 1001FE991 10020D098
// BRE and BRN, taken and not taken; A1..A4 must show, B1 and B3 never
10021EA25 10022900A 10023ECB1 10024D0CC 10025ECA1 10026D0CC
10027910A 10028ECA2 10029D0CC 1002AEA2E 1002BA10A 1002CECB3
1002DD0CC 1002EECA3 1002FD0CC 10030A00A 10031ECA4 10032D0CC
// Jump and link to 0036, link 0035 stored; RES at 0037, store behind it
10033EA36 100348DA0 10035D0CC 10036D0DD 10037B000 10038D011
// Preloaded data words
20080BEEF 200811357
// Expected store trace
312341234 3F00FF00F 302430243 322252225 310041004 3F23FF23F
3E23BE23B 300910091 300F000F0 300010001 300000000
30090BEEF 300911357
300A100A1 300A200A2 300A300A3 300A400A4 300350035
// Halt pc
400370000

// ==== sim.f ====
+incdir+src
src/nbbpu_pkg.sv
src/controller.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/nbbpu.sv
verification/tb_clock.sv
verification/nbbpu_asserts.sv
verification/tb_nbbpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the NBBPU testbench with Verilator and runs it from the project root.
# The run passes only when the pass message appears in the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_nbbpu -f sim.f -o sim_nbbpu \
    && ./obj_dir/sim_nbbpu +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -qF '*** TEST PASSED ***' \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
